// ==== cbc_consts.svh ====
// Size constants for the AES-128 CBC core
`ifndef CBC_CONSTS_SVH
`define CBC_CONSTS_SVH

// Cipher key width in bits
`define AES_KEY_BITS 128

// Number of rounds, one more round key than this
`define AES_ROUNDS 10

// Data block width in bits
`define AES_BLOCK_BITS 128

`endif

// ==== cbc_pkg.sv ====
// Shared types of the AES-128 CBC core: block, round key and command bundle
`include "cbc_consts.svh"

package cbc_pkg;

  // One state block, seen flat for XOR or as four columns
  // col[3] is AES column 0, row 0 sits in its top byte
  typedef union packed {
    logic [`AES_BLOCK_BITS-1:0]          flat;
    logic [`AES_BLOCK_BITS/32-1:0][31:0] col;
  } aes_block_t;

  // Round key as four words, w0 in the top word
  typedef logic [`AES_KEY_BITS/32-1:0][31:0] round_key_t;

  // Round key index, 0 to AES_ROUNDS
  typedef logic [3:0] rk_index_t;

  // Everything the host presents with one command
  typedef struct packed {
    logic       init_cmd;
    logic       next_cmd;
    // High for encipher, low for decipher
    logic       encdec;
    round_key_t key;
    aes_block_t iv;
    aes_block_t block;
  } cbc_cmd_t;

endpackage

// ==== aes_sbox.sv ====
// Four-byte AES S-box, forward or inverse, built on GF(2^8) inversion
`timescale 1ns/1ps

module aes_sbox (
  input  logic [31:0] sbox_req,
  input  logic        inverse,
  output logic [31:0] sbox_word
);

  // Product modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] aa;
    p  = 8'h00;
    aa = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        p = p ^ aa;
      end
      aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // Inverse as x^254, zero maps to zero
  function automatic logic [7:0] gf_inv(input logic [7:0] x);
    logic [7:0] r;
    logic [7:0] p;
    r = 8'h01;
    p = x;
    // Accumulate x^2 * x^4 * ... * x^128
    for (int i = 0; i < 7; i++) begin
      p = gf_mul(p, p);
      r = gf_mul(r, p);
    end
    return r;
  endfunction

  function automatic logic [7:0] rotl8(input logic [7:0] a, input int n);
    return (a << n) | (a >> (8 - n));
  endfunction

  // Forward affine map, constant 0x63
  function automatic logic [7:0] fwd_affine(input logic [7:0] a);
    return a ^ rotl8(a, 1) ^ rotl8(a, 2) ^ rotl8(a, 3) ^ rotl8(a, 4) ^ 8'h63;
  endfunction

  // Inverse affine map, constant 0x05
  function automatic logic [7:0] inv_affine(input logic [7:0] a);
    return rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05;
  endfunction

  // Four independent byte lanes
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      if (inverse) begin
        sbox_word[8*b +: 8] = gf_inv(inv_affine(sbox_req[8*b +: 8]));
      end else begin
        sbox_word[8*b +: 8] = fwd_affine(gf_inv(sbox_req[8*b +: 8]));
      end
    end
  end

endmodule

// ==== aes_key_expander.sv ====
// AES-128 key schedule, one round key written to the key store per cycle
`timescale 1ns/1ps
`include "cbc_consts.svh"

module aes_key_expander
  import cbc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        zeroize,
  input  logic        start,
  input  round_key_t  key,
  output logic [31:0] sbox_req,
  input  logic [31:0] sbox_word,
  output logic        rk_we,
  output rk_index_t   rk_index,
  output round_key_t  rk_data,
  output logic        key_ready
);

  // Current round key and its successor
  round_key_t cur_key;
  round_key_t next_key;
  // Round constant for the step from cur_key
  logic [7:0] rcon;
  rk_index_t  idx;
  logic       busy;

  // RotWord of w3, substituted by the shared S-box
  assign sbox_req = {cur_key[0][23:0], cur_key[0][31:24]};

  // Every busy cycle stores the current key
  assign rk_we    = busy;
  assign rk_index = idx;
  assign rk_data  = cur_key;

  ////////////////////////////////////////////////////////////
  // Next round key
  ////////////////////////////////////////////////////////////
  always_comb begin
    next_key[3] = cur_key[3] ^ sbox_word ^ {rcon, 24'h000000};
    next_key[2] = cur_key[2] ^ next_key[3];
    next_key[1] = cur_key[1] ^ next_key[2];
    next_key[0] = cur_key[0] ^ next_key[1];
  end

  always_ff @(posedge clk) begin
    if (reset || zeroize) begin
      cur_key   <= '0;
      rcon      <= 8'h01;
      idx       <= '0;
      busy      <= 1'b0;
      key_ready <= 1'b0;
    end else begin
      key_ready <= 1'b0;
      if (start) begin
        // Cipher key is round key 0
        cur_key <= key;
        rcon    <= 8'h01;
        idx     <= '0;
        busy    <= 1'b1;
      end else if (busy) begin
        cur_key <= next_key;
        // xtime of the round constant
        rcon    <= {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
        idx     <= idx + 1'b1;
        // Last key written this cycle
        if (idx == rk_index_t'(`AES_ROUNDS)) begin
          busy      <= 1'b0;
          key_ready <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== aes_round_key_mem.sv ====
// Round key store, one write port and one asynchronous read port
`timescale 1ns/1ps
`include "cbc_consts.svh"

module aes_round_key_mem
  import cbc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       zeroize,
  input  logic       we,
  input  rk_index_t  windex,
  input  round_key_t wdata,
  input  rk_index_t  rindex,
  output round_key_t rdata
);

  // Round keys 0 to AES_ROUNDS
  round_key_t keys [0:`AES_ROUNDS];

  // Key material must not survive zeroize
  always_ff @(posedge clk) begin
    if (reset || zeroize) begin
      for (int i = 0; i <= `AES_ROUNDS; i++) begin
        keys[i] <= '0;
      end
    end else if (we && (windex <= rk_index_t'(`AES_ROUNDS))) begin
      keys[windex] <= wdata;
    end
  end

  // Out of range index reads zero
  assign rdata = (rindex <= rk_index_t'(`AES_ROUNDS)) ? keys[rindex] : '0;

endmodule

// ==== aes_cipher_engine.sv ====
// Iterative AES-128 encipher and decipher datapath, one S-box column per cycle
`timescale 1ns/1ps
`include "cbc_consts.svh"

module aes_cipher_engine
  import cbc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        zeroize,
  input  logic        start,
  input  logic        encdec,
  input  aes_block_t  block_in,
  output rk_index_t   rk_index,
  input  round_key_t  rk_data,
  output logic [31:0] sbox_req,
  output logic        sbox_inverse,
  input  logic [31:0] sbox_word,
  output logic        done,
  output aes_block_t  new_block
);

  aes_block_t state;
  // Round step intermediates
  aes_block_t shifted;
  aes_block_t keyed;
  aes_block_t mixed;
  aes_block_t step_out;
  // Round 1 to AES_ROUNDS
  rk_index_t  round;
  // 0..3 substitute a column, 4 does the rest of the round
  logic [2:0] phase;
  logic       busy;
  logic       enc_mode;
  logic       final_round;

  ////////////////////////////////////////////////////////////
  // Round functions
  ////////////////////////////////////////////////////////////
  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // Row r rotates left by r, or right by r for the inverse
  function automatic aes_block_t shift_rows(input aes_block_t s, input logic inv);
    aes_block_t r;
    int         src;
    r = s;
    for (int c = 0; c < 4; c++) begin
      for (int row = 0; row < 4; row++) begin
        src = inv ? (c - row + 4) % 4 : (c + row) % 4;
        r.col[3 - c][31 - 8*row -: 8] = s.col[3 - src][31 - 8*row -: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [31:0] mix_column(input logic [31:0] a);
    logic [7:0] a0;
    logic [7:0] a1;
    logic [7:0] a2;
    logic [7:0] a3;
    a0 = a[31:24];
    a1 = a[23:16];
    a2 = a[15:8];
    a3 = a[7:0];
    // 2*ai ^ 3*ai+1 ^ ai+2 ^ ai+3
    return {xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
            xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0,
            xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1,
            xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2};
  endfunction

  // InvMixColumns as a 4*x^2 preprocessing step followed by MixColumns
  function automatic logic [31:0] inv_mix_column(input logic [31:0] a);
    logic [7:0] u;
    logic [7:0] v;
    u = xtime(xtime(a[31:24] ^ a[15:8]));
    v = xtime(xtime(a[23:16] ^ a[7:0]));
    return mix_column(a ^ {u, v, u, v});
  endfunction

  function automatic aes_block_t mix_block(input aes_block_t s, input logic inv);
    aes_block_t r;
    r = s;
    for (int c = 0; c < 4; c++) begin
      r.col[c] = inv ? inv_mix_column(s.col[c]) : mix_column(s.col[c]);
    end
    return r;
  endfunction

  assign final_round = (round == rk_index_t'(`AES_ROUNDS));

  // Decipher walks the keys from the top down
  always_comb begin
    if (busy) begin
      rk_index = enc_mode ? round : rk_index_t'(`AES_ROUNDS) - round;
    end else begin
      // Whitening key for the block about to start
      rk_index = encdec ? rk_index_t'(0) : rk_index_t'(`AES_ROUNDS);
    end
  end

  // Column under substitution
  assign sbox_req     = state.col[2'd3 - phase[1:0]];
  assign sbox_inverse = !enc_mode;

  ////////////////////////////////////////////////////////////
  // Rest of the round after SubBytes
  ////////////////////////////////////////////////////////////
  always_comb begin
    shifted    = shift_rows(state, !enc_mode);
    keyed.flat = shifted.flat ^ rk_data;
    // Encipher mixes before the key, decipher after
    mixed      = mix_block(enc_mode ? shifted : keyed, !enc_mode);
    if (enc_mode) begin
      step_out.flat = (final_round ? shifted.flat : mixed.flat) ^ rk_data;
    end else begin
      step_out = final_round ? keyed : mixed;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || zeroize) begin
      state    <= '0;
      round    <= '0;
      phase    <= '0;
      busy     <= 1'b0;
      enc_mode <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        // Initial AddRoundKey
        state.flat <= block_in.flat ^ rk_data;
        enc_mode   <= encdec;
        round      <= rk_index_t'(1);
        phase      <= '0;
        busy       <= 1'b1;
      end else if (busy) begin
        if (phase != 3'd4) begin
          state.col[2'd3 - phase[1:0]] <= sbox_word;
          phase <= phase + 3'd1;
        end else begin
          state <= step_out;
          phase <= '0;
          round <= round + 1'b1;
          if (final_round) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end
    end
  end

  // State holds the finished block while done is high
  assign new_block = state;

endmodule

// ==== cbc_ctrl.sv ====
// CBC command sequencer with chain register, S-box request mux and result register
`timescale 1ns/1ps

module cbc_ctrl
  import cbc_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  cbc_cmd_t    cmd,
  input  logic        zeroize,
  // Key expander
  output logic        ke_start,
  output round_key_t  ke_key,
  input  logic [31:0] ke_sbox_req,
  input  logic        key_ready,
  // Cipher engine
  output logic        eng_start,
  output logic        eng_encdec,
  output aes_block_t  eng_block,
  input  logic [31:0] eng_sbox_req,
  input  logic        eng_sbox_inverse,
  input  logic        eng_done,
  input  aes_block_t  eng_new_block,
  // Shared S-box
  output logic [31:0] sbox_req,
  output logic        sbox_inverse,
  // Host side
  output logic        ready,
  output logic        result_valid,
  output aes_block_t  result
);

  typedef enum logic [1:0] {ST_IDLE, ST_EXPAND, ST_BLOCK} ctrl_state_t;

  ctrl_state_t state;
  aes_block_t  chain;
  // Ciphertext of a decipher, next chain value
  aes_block_t  saved_block;
  logic        enc_mode;
  logic        accept_init;
  logic        accept_next;

  // Init wins if both strobes are raised
  assign accept_init = ready && cmd.init_cmd;
  assign accept_next = ready && cmd.next_cmd && !cmd.init_cmd;

  assign ke_start   = accept_init;
  assign ke_key     = cmd.key;
  assign eng_start  = accept_next;
  assign eng_encdec = cmd.encdec;
  // Plaintext is chained before enciphering
  assign eng_block.flat = cmd.encdec ? (cmd.block.flat ^ chain.flat) : cmd.block.flat;

  // Expander owns the S-box only while expanding
  assign sbox_req     = (state == ST_EXPAND) ? ke_sbox_req : eng_sbox_req;
  assign sbox_inverse = (state == ST_EXPAND) ? 1'b0 : eng_sbox_inverse;

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || zeroize) begin
      state        <= ST_IDLE;
      ready        <= 1'b0;
      result_valid <= 1'b0;
      result       <= '0;
      chain        <= '0;
      saved_block  <= '0;
      enc_mode     <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      case (state)
        ST_IDLE: begin
          ready <= !(accept_init || accept_next);
          if (accept_init) begin
            chain <= cmd.iv;
            state <= ST_EXPAND;
          end else if (accept_next) begin
            enc_mode    <= cmd.encdec;
            saved_block <= cmd.block;
            state       <= ST_BLOCK;
          end
        end
        ST_EXPAND: begin
          if (key_ready) begin
            ready <= 1'b1;
            state <= ST_IDLE;
          end
        end
        ST_BLOCK: begin
          if (eng_done) begin
            if (enc_mode) begin
              result <= eng_new_block;
              chain  <= eng_new_block;
            end else begin
              result.flat <= eng_new_block.flat ^ chain.flat;
              chain       <= saved_block;
            end
            result_valid <= 1'b1;
            ready        <= 1'b1;
            state        <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== cbc_core.sv ====
// AES-128 CBC core top level, sequencer with key schedule, key store, engine and S-box
`timescale 1ns/1ps

module cbc_core
  import cbc_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  cbc_cmd_t   cmd,
  input  logic       zeroize,
  output logic       ready,
  output logic       result_valid,
  output aes_block_t result
);

  // Key expander side
  logic        ke_start;
  round_key_t  ke_key;
  logic [31:0] ke_sbox_req;
  logic        key_ready;
  logic        rk_we;
  rk_index_t   rk_windex;
  round_key_t  rk_wdata;
  // Engine side
  logic        eng_start;
  logic        eng_encdec;
  aes_block_t  eng_block;
  rk_index_t   rk_rindex;
  round_key_t  rk_rdata;
  logic [31:0] eng_sbox_req;
  logic        eng_sbox_inverse;
  logic        eng_done;
  aes_block_t  eng_new_block;
  // Shared S-box, output fans out to both users
  logic [31:0] sbox_req;
  logic        sbox_inverse;
  logic [31:0] sbox_word;

  cbc_ctrl i_cbc_ctrl (
    .clk              (clk),
    .reset            (reset),
    .cmd              (cmd),
    .zeroize          (zeroize),
    .ke_start         (ke_start),
    .ke_key           (ke_key),
    .ke_sbox_req      (ke_sbox_req),
    .key_ready        (key_ready),
    .eng_start        (eng_start),
    .eng_encdec       (eng_encdec),
    .eng_block        (eng_block),
    .eng_sbox_req     (eng_sbox_req),
    .eng_sbox_inverse (eng_sbox_inverse),
    .eng_done         (eng_done),
    .eng_new_block    (eng_new_block),
    .sbox_req         (sbox_req),
    .sbox_inverse     (sbox_inverse),
    .ready            (ready),
    .result_valid     (result_valid),
    .result           (result)
  );

  aes_key_expander i_aes_key_expander (
    .clk       (clk),
    .reset     (reset),
    .zeroize   (zeroize),
    .start     (ke_start),
    .key       (ke_key),
    .sbox_req  (ke_sbox_req),
    .sbox_word (sbox_word),
    .rk_we     (rk_we),
    .rk_index  (rk_windex),
    .rk_data   (rk_wdata),
    .key_ready (key_ready)
  );

  aes_round_key_mem i_aes_round_key_mem (
    .clk     (clk),
    .reset   (reset),
    .zeroize (zeroize),
    .we      (rk_we),
    .windex  (rk_windex),
    .wdata   (rk_wdata),
    .rindex  (rk_rindex),
    .rdata   (rk_rdata)
  );

  aes_cipher_engine i_aes_cipher_engine (
    .clk          (clk),
    .reset        (reset),
    .zeroize      (zeroize),
    .start        (eng_start),
    .encdec       (eng_encdec),
    .block_in     (eng_block),
    .rk_index     (rk_rindex),
    .rk_data      (rk_rdata),
    .sbox_req     (eng_sbox_req),
    .sbox_inverse (eng_sbox_inverse),
    .sbox_word    (sbox_word),
    .done         (eng_done),
    .new_block    (eng_new_block)
  );

  aes_sbox i_aes_sbox (
    .sbox_req  (sbox_req),
    .inverse   (sbox_inverse),
    .sbox_word (sbox_word)
  );

endmodule

// ==== tb_cbc_core.sv ====
// Self-checking testbench for the AES-128 CBC core, driven by the vectors in cbc_tests.txt
`timescale 1ns/1ps

module tb_cbc_core
  import cbc_pkg::*;
();

  localparam string TESTS_FILE = "cbc_tests.txt";
  // Room for the longest text line
  localparam int LINE_BITS = 8 * 256;
  // Cycle budget for each operation line
  localparam int CYCLES_PER_LINE = 2000;

  logic       clk;
  logic       reset;
  cbc_cmd_t   cmd;
  logic       zeroize;
  logic       ready;
  logic       result_valid;
  aes_block_t result;

  // Idle gap source
  logic [31:0] lcg_state;
  int          cycle_count;
  int          cycle_limit;

  cbc_core i_cbc_core (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd),
    .zeroize      (zeroize),
    .ready        (ready),
    .result_valid (result_valid),
    .result       (result)
  );

  // 100 ns clock
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////
  task automatic stop_failed();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped after a failure");
  endtask

  task automatic check_block(input string what, input aes_block_t actual,
                             input aes_block_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s expected %h got %h", $time, what,
               expected.flat, actual.flat);
      stop_failed();
    end
  endtask

  task automatic check_flag(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s expected %b got %b", $time, what, expected, actual);
      stop_failed();
    end
  endtask

  // Run limit, scaled to the number of test lines
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
      stop_failed();
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // Between base and base+span-1 idle cycles
  task automatic random_gap(input int base, input int span);
    int n;
    lcg_state = lcg_next(lcg_state);
    n = base + int'(lcg_state[23:16]) % span;
    idle_cycles(n);
  endtask

  // Outputs are sampled on the falling edge
  task automatic wait_ready();
    @(negedge clk);
    while (ready !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  // One result_valid pulse with ready, then quiet
  task automatic wait_result(input aes_block_t expected);
    @(negedge clk);
    while (result_valid !== 1'b1) begin
      check_flag("ready while block is busy", ready, 1'b0);
      @(negedge clk);
    end
    check_block("result", result, expected);
    check_flag("ready together with result_valid", ready, 1'b1);
    @(negedge clk);
    check_flag("result_valid pulse width", result_valid, 1'b0);
  endtask

  task automatic run_init(input logic [127:0] key_in, input logic [127:0] iv_in);
    wait_ready();
    random_gap(0, 4);
    @(posedge clk);
    cmd.init_cmd <= 1'b1;
    cmd.key      <= key_in;
    cmd.iv.flat  <= iv_in;
    // Accepted on this edge
    @(posedge clk);
    cmd.init_cmd <= 1'b0;
    @(negedge clk);
    check_flag("ready drop after init_cmd", ready, 1'b0);
    while (ready !== 1'b1) begin
      check_flag("result_valid during key expansion", result_valid, 1'b0);
      @(negedge clk);
    end
    check_flag("result_valid at end of key expansion", result_valid, 1'b0);
  endtask

  // stray raises a second next_cmd while the block is busy
  task automatic run_block(input logic enc, input logic [127:0] blk_in,
                           input logic [127:0] exp_in, input logic stray);
    aes_block_t expected;
    expected.flat = exp_in;
    wait_ready();
    random_gap(0, 4);
    @(posedge clk);
    cmd.next_cmd   <= 1'b1;
    cmd.encdec     <= enc;
    cmd.block.flat <= blk_in;
    @(posedge clk);
    cmd.next_cmd <= 1'b0;
    @(negedge clk);
    check_flag("ready drop after next_cmd", ready, 1'b0);
    if (stray) begin
      @(posedge clk);
      cmd.next_cmd   <= 1'b1;
      cmd.encdec     <= !enc;
      cmd.block.flat <= ~blk_in;
      // Dropped well before the block completes
      repeat (3) @(posedge clk);
      cmd.next_cmd <= 1'b0;
    end
    wait_result(expected);
  endtask

  task automatic run_zeroize();
    aes_block_t zero_block;
    zero_block.flat = '0;
    wait_ready();
    random_gap(0, 4);
    @(posedge clk);
    zeroize <= 1'b1;
    @(posedge clk);
    zeroize <= 1'b0;
    @(negedge clk);
    check_flag("ready cleared by zeroize", ready, 1'b0);
    check_block("result cleared by zeroize", result, zero_block);
    // Ready returns one cycle later
    @(negedge clk);
    check_flag("ready after zeroize", ready, 1'b1);
    check_block("result after zeroize", result, zero_block);
    check_flag("result_valid after zeroize", result_valid, 1'b0);
  endtask

  task automatic require_operands(input int n, input int line_no);
    if (n != 3) begin
      $display("Test line %0d is missing its two hex operands", line_no);
      stop_failed();
    end
  endtask

  // Operation lines, skipping comments and blanks
  task automatic count_ops(output int ops);
    int                   fd;
    int                   n;
    logic [LINE_BITS-1:0] line;
    logic [63:0]          op;
    ops = 0;
    fd  = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the test file %s", TESTS_FILE);
      stop_failed();
    end else begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%s", op);
        if (n == 1 && op != 64'("#")) begin
          ops++;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin : main
    int                   fd;
    int                   n;
    int                   ops;
    int                   line_no;
    logic [LINE_BITS-1:0] line;
    logic [63:0]          op;
    logic [127:0]         arg_a;
    logic [127:0]         arg_b;
    aes_block_t           zero_block;

    cmd        = '0;
    zeroize    = 1'b0;
    reset      = 1'b1;
    lcg_state  = 32'ha894;
    zero_block.flat = '0;
    line_no    = 0;

    count_ops(ops);
    cycle_limit = CYCLES_PER_LINE * (ops + 1);

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    wait_ready();
    check_block("result after reset", result, zero_block);
    check_flag("result_valid after reset", result_valid, 1'b0);

    fd = $fopen(TESTS_FILE, "r");
    while ($fgets(line, fd) != 0) begin
      line_no++;
      n = $sscanf(line, "%s %h %h", op, arg_a, arg_b);
      if (n >= 1 && op != 64'("#")) begin
        case (op)
          64'("init"): begin
            require_operands(n, line_no);
            run_init(arg_a, arg_b);
          end
          64'("enc"): begin
            require_operands(n, line_no);
            run_block(1'b1, arg_a, arg_b, 1'b0);
          end
          64'("dec"): begin
            require_operands(n, line_no);
            run_block(1'b0, arg_a, arg_b, 1'b0);
          end
          // Encipher with a strobe raised while busy
          64'("busy"): begin
            require_operands(n, line_no);
            run_block(1'b1, arg_a, arg_b, 1'b1);
          end
          64'("zeroize"): begin
            run_zeroize();
          end
          64'("gap"): begin
            random_gap(4, 8);
          end
          default: begin
            $display("Test line %0d has an unknown operation", line_no);
            stop_failed();
          end
        endcase
      end
    end
    $fclose(fd);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== cbc_tests.txt ====
# Columns: operation, then up to two 128-bit hex operands
# init KEY IV | enc BLOCK EXPECTED | dec BLOCK EXPECTED | busy BLOCK EXPECTED | zeroize | gap
init 000102030405060708090a0b0c0d0e0f 00000000000000000000000000000000
enc 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
init 000102030405060708090a0b0c0d0e0f 00000000000000000000000000000000
dec 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
gap
init 2b7e151628aed2a6abf7158809cf4f3c 000102030405060708090a0b0c0d0e0f
enc 6bc1bee22e409f96e93d7e117393172a 7649abac8119b246cee98e9b12e9197d
enc ae2d8a571e03ac9c9eb76fac45af8e51 5086cb9b507219ee95db113a917678b2
enc 30c81c46a35ce411e5fbc1191a0a52ef 73bed6b8e3c1743b7116e69e22229516
enc f69f2445df4f9b17ad2b417be66c3710 3ff1caa1681fac09120eca307586e1a7
gap
init 2b7e151628aed2a6abf7158809cf4f3c 000102030405060708090a0b0c0d0e0f
dec 7649abac8119b246cee98e9b12e9197d 6bc1bee22e409f96e93d7e117393172a
dec 5086cb9b507219ee95db113a917678b2 ae2d8a571e03ac9c9eb76fac45af8e51
dec 73bed6b8e3c1743b7116e69e22229516 30c81c46a35ce411e5fbc1191a0a52ef
dec 3ff1caa1681fac09120eca307586e1a7 f69f2445df4f9b17ad2b417be66c3710
zeroize
init 000102030405060708090a0b0c0d0e0f 00000000000000000000000000000000
enc 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
gap
init 2b7e151628aed2a6abf7158809cf4f3c 000102030405060708090a0b0c0d0e0f
busy 6bc1bee22e409f96e93d7e117393172a 7649abac8119b246cee98e9b12e9197d
enc ae2d8a571e03ac9c9eb76fac45af8e51 5086cb9b507219ee95db113a917678b2

// ==== vlog.f ====
+incdir+.
cbc_pkg.sv
aes_sbox.sv
aes_key_expander.sv
aes_round_key_mem.sv
aes_cipher_engine.sv
cbc_ctrl.sv
cbc_core.sv
tb_cbc_core.sv

// ==== Makefile ====
TOP := tb_cbc_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
